// ==== dv/except_unit_tb.sv ====
`timescale 1ns/1ps

module except_unit_tb
    import csr_pkg::*;
    import pipe_pkg::*;
();

    localparam logic [31:0] eentry_rst = 32'h1c00_8000;
    localparam int cycles_per_test = 160;
    localparam int num_tests = 6;
    localparam int watchdog_ns = (8 + num_tests * (cycles_per_test + 1) + 50) * 20;
    // ade and ale appear twice so the bad address latch is hit often.
    localparam logic [5:0] code_table [16] = '{
        6'h00, 6'h01, 6'h02, 6'h03, 6'h04, 6'h07, 6'h08, 6'h09,
        6'h0b, 6'h0c, 6'h0d, 6'h0e, 6'h0f, 6'h12, 6'h08, 6'h09
    };

    logic                            clk;
    logic                            rst_i;
    logic [31:0]                     mem_pc_i;
    logic [exc_slots-1:0]            mem_exc_valid_i;
    logic [exc_slots*exc_code_w-1:0] mem_exc_code_i;
    logic [31:0]                     mem_bad_addr_i;
    logic                            mem_ertn_i;
    logic                            mem_idle_i;
    logic                            csr_we_i;
    logic [csr_addr_w-1:0]           csr_waddr_i;
    logic [31:0]                     csr_wdata_i;
    logic                            pause_if_i;
    logic                            pause_id_i;
    logic                            pause_dispatch_i;
    logic                            pause_ex_i;
    logic                            pause_mem_i;
    logic                            continue_idle_i;
    logic [hw_irq_lines-1:0]         irq_i;
    logic [csr_addr_w-1:0]           csr_raddr_i;
    logic                            flush_o;
    logic [31:0]                     new_pc_o;
    logic [pause_w-1:0]              pause_o;
    logic                            issue_en_o;
    logic                            int_pending_o;
    logic [31:0]                     csr_rdata_o;

    // model CSR images hold only the implemented bits.
    logic [31:0] m_crmd;
    logic [31:0] m_prmd;
    logic [31:0] m_ecfg;
    logic [31:0] m_estat;
    logic [31:0] m_era;
    logic [31:0] m_eentry;
    logic [31:0] m_badv;
    logic [31:0] lfsr;
    logic        check_en;
    int          err_count;
    int          failed_tests;

    except_unit #(
        .eentry_reset (eentry_rst)
    ) i_dut (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r[i] = lfsr[0];
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1); // galois step.
        end
        return r;
    endfunction

    function automatic logic [13:0] pick_addr();
        logic [31:0] r;
        r = take_bits(3);
        case (r[2:0])
            3'd0: return csr_addr_crmd;
            3'd1: return csr_addr_prmd;
            3'd2: return csr_addr_ecfg;
            3'd3: return csr_addr_estat;
            3'd4: return csr_addr_era;
            3'd5: return csr_addr_badv;
            3'd6: return csr_addr_eentry;
            default: begin
                r = take_bits(14);
                return r[13:0];
            end
        endcase
    endfunction

    function automatic logic [31:0] model_read(input logic [13:0] a);
        case (a)
            csr_addr_crmd:   return m_crmd;
            csr_addr_prmd:   return m_prmd;
            csr_addr_ecfg:   return m_ecfg;
            csr_addr_estat:  return m_estat;
            csr_addr_era:    return m_era;
            csr_addr_badv:   return m_badv;
            csr_addr_eentry: return m_eentry;
            default:         return 32'h0;
        endcase
    endfunction

    // returns {flush, new pc, pause, issue enable, interrupt pending}.
    function automatic logic [41:0] expected_outputs();
        logic [31:0] crmd_f;
        logic [31:0] ecfg_f;
        logic [31:0] estat_f;
        logic [31:0] era_f;
        logic [31:0] eentry_f;
        logic        pend;
        logic        taken;
        logic [6:0]  pv;
        crmd_f = (csr_we_i && csr_waddr_i == csr_addr_crmd) ? csr_wdata_i : m_crmd;
        ecfg_f = (csr_we_i && csr_waddr_i == csr_addr_ecfg) ? csr_wdata_i : m_ecfg;
        estat_f = (csr_we_i && csr_waddr_i == csr_addr_estat) ? csr_wdata_i : m_estat;
        era_f = (csr_we_i && csr_waddr_i == csr_addr_era) ? csr_wdata_i : m_era;
        eentry_f = (csr_we_i && csr_waddr_i == csr_addr_eentry) ? csr_wdata_i : m_eentry;
        eentry_f[5:0] = 6'b0;
        pend = crmd_f[2] && ((ecfg_f & estat_f & 32'h1bff) != 0); // bit 10 is not a line.
        taken = mem_exc_valid_i != 0;
        pv = 7'b0000000;
        if (pause_if_i)
            pv = 7'b0000001;
        else if (pause_id_i)
            pv = 7'b0000111;
        else if (pause_dispatch_i)
            pv = 7'b0001111;
        else if (pause_ex_i)
            pv = 7'b0011111;
        else if (pause_mem_i || (mem_idle_i && !pend && !continue_idle_i))
            pv = 7'b0111111;
        return {taken || mem_ertn_i, (mem_ertn_i && !taken) ? era_f : eentry_f, pv, !pv[1], pend};
    endfunction

    function automatic void update_model();
        logic [31:0] crmd_c;
        logic [31:0] prmd_c;
        logic [5:0]  cause;
        if (rst_i) begin
            m_crmd = '0;
            m_prmd = '0;
            m_ecfg = '0;
            m_estat = '0;
            m_era = '0;
            m_badv = '0;
            m_eentry = eentry_rst & 32'hffff_ffc0;
            return;
        end
        crmd_c = (csr_we_i && csr_waddr_i == csr_addr_crmd) ? (csr_wdata_i & 32'h7) : m_crmd;
        prmd_c = (csr_we_i && csr_waddr_i == csr_addr_prmd) ? (csr_wdata_i & 32'h7) : m_prmd;
        if (csr_we_i) begin
            case (csr_waddr_i)
                csr_addr_ecfg:   m_ecfg = csr_wdata_i & 32'h1bff;
                csr_addr_estat:  m_estat = (m_estat & ~32'h1803) | (csr_wdata_i & 32'h1803);
                csr_addr_era:    m_era = csr_wdata_i;
                csr_addr_eentry: m_eentry = csr_wdata_i & 32'hffff_ffc0;
                default: ;
            endcase
        end
        m_estat[9:2] = irq_i;
        cause = 6'h3f;
        for (int s = exc_slots - 1; s >= 0; s--) begin
            if (mem_exc_valid_i[s] && cause == 6'h3f)
                cause = mem_exc_code_i[s*6 +: 6];
        end
        if (mem_exc_valid_i != 0) begin
            m_prmd = crmd_c;
            m_crmd = '0;
            m_era = mem_pc_i;
            m_estat[21:16] = cause;
            if (cause == 6'h08 || cause == 6'h09)
                m_badv = mem_bad_addr_i;
        end else begin
            m_crmd = mem_ertn_i ? prmd_c : crmd_c;
            m_prmd = prmd_c;
        end
    endfunction

    task automatic flag_mismatch(input string what, input logic [31:0] got,
                                 input logic [31:0] exp);
        $display("ERR %0t: %s is %h, expected %h", $time, what, got, exp);
        err_count++;
    endtask

    // outputs are settled here, well after the inputs move at 2 ns.
    initial begin
        logic [41:0] exp;
        forever begin
            @(posedge clk);
            #18;
            exp = expected_outputs();
            if (check_en) begin
                if (flush_o !== exp[41])
                    flag_mismatch("flush_o", flush_o, exp[41]);
                if (new_pc_o !== exp[40:9])
                    flag_mismatch("new_pc_o", new_pc_o, exp[40:9]);
                if (pause_o !== exp[8:2])
                    flag_mismatch("pause_o", pause_o, exp[8:2]);
                if (issue_en_o !== exp[1])
                    flag_mismatch("issue_en_o", issue_en_o, exp[1]);
                if (int_pending_o !== exp[0])
                    flag_mismatch("int_pending_o", int_pending_o, exp[0]);
                if (csr_rdata_o !== model_read(csr_raddr_i))
                    flag_mismatch("csr_rdata_o", csr_rdata_o, model_read(csr_raddr_i));
            end
            update_model();
        end
    end

    task automatic drive_cycle(input int mode);
        mem_exc_valid_i = '0;
        mem_exc_code_i = '0;
        mem_ertn_i = 1'b0;
        mem_idle_i = 1'b0;
        continue_idle_i = 1'b0;
        {pause_if_i, pause_id_i, pause_dispatch_i, pause_ex_i, pause_mem_i} = 5'b0;
        irq_i = '0;
        mem_pc_i = take_bits(32);
        mem_bad_addr_i = take_bits(32);
        csr_raddr_i = pick_addr();
        csr_we_i = (mode >= 2) ? take_bits(1) : 1'b0;
        csr_waddr_i = pick_addr();
        csr_wdata_i = take_bits(32);
        case (mode)
            1: {pause_if_i, pause_id_i, pause_dispatch_i, pause_ex_i, pause_mem_i} = take_bits(5);
            2: begin
                mem_exc_valid_i = take_bits(6) & take_bits(6);
                for (int s = 0; s < exc_slots; s++)
                    mem_exc_code_i[s*6 +: 6] = code_table[take_bits(4)];
            end
            3: begin
                mem_ertn_i = take_bits(1);
                if (take_bits(3) == 0)
                    mem_exc_valid_i = take_bits(6);
                csr_raddr_i = take_bits(1) ? csr_addr_crmd : csr_addr_prmd;
            end
            4: begin
                irq_i = take_bits(8) & take_bits(8);
                if (take_bits(1))
                    csr_waddr_i = take_bits(1) ? csr_addr_crmd : csr_addr_ecfg;
            end
            5: begin
                mem_idle_i = take_bits(2) != 0;
                continue_idle_i = take_bits(3) == 0;
                irq_i = take_bits(8) & take_bits(8) & take_bits(8);
                pause_mem_i = take_bits(3) == 0;
            end
            default: ;
        endcase
    endtask

    task automatic run_test(input string name, input int mode);
        int errs_before;
        errs_before = err_count;
        for (int i = 0; i < cycles_per_test; i++) begin
            @(posedge clk);
            #2;
            drive_cycle(mode);
            rst_i = (mode == 6) && (i == 80 || i == 81); // a second reset mid test.
        end
        @(posedge clk);
        if (err_count == errs_before) begin
            $display("[%s] ok after %0d cycles", name, cycles_per_test);
        end else begin
            $display("[%s] %0d mismatches", name, err_count - errs_before);
            failed_tests++;
        end
    endtask

    initial begin
        #(watchdog_ns);
        $display("simulation timed out after %0t with the tests still running", $time);
        $display("test failed");
        $finish;
    end

    initial begin
        lfsr = 32'h20a290d1;
        err_count = 0;
        failed_tests = 0;
        check_en = 1'b0;
        rst_i = 1'b1;
        drive_cycle(0);
        repeat (8) @(posedge clk);
        #2;
        rst_i = 1'b0;
        check_en = 1'b1;
        run_test("pause_priority", 1);
        run_test("exception_select", 2);
        run_test("ertn_return", 3);
        run_test("interrupt_pending", 4);
        run_test("idle_wakeup", 5);
        run_test("csr_readback", 6);
        $display("%0d tests run, %0d failing, %0d mismatches", num_tests, failed_tests,
                 err_count);
        if (err_count == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

// ==== filelist.f ====
logic/csr_pkg.sv
logic/pipe_pkg.sv
logic/exc_select.sv
logic/int_check.sv
logic/csr_regs.sv
logic/trap_ctrl.sv
logic/except_unit.sv
dv/except_unit_tb.sv

// ==== logic/csr_pkg.sv ====
package csr_pkg;

    localparam int csr_addr_w = 14;

    localparam logic [csr_addr_w-1:0] csr_addr_crmd   = 14'h0;
    localparam logic [csr_addr_w-1:0] csr_addr_prmd   = 14'h1;
    localparam logic [csr_addr_w-1:0] csr_addr_ecfg   = 14'h4;
    localparam logic [csr_addr_w-1:0] csr_addr_estat  = 14'h5;
    localparam logic [csr_addr_w-1:0] csr_addr_era    = 14'h6;
    localparam logic [csr_addr_w-1:0] csr_addr_badv   = 14'h7;
    localparam logic [csr_addr_w-1:0] csr_addr_eentry = 14'hc;

    // privilege level field of CRMD and PRMD.
    localparam int plv_w = 2;

    // global interrupt enable sits above PLV in both CRMD and PRMD.
    localparam int crmd_ie_bit = 2;

    // exception code field of ESTAT, bits 21 to 16.
    localparam int ecode_lsb = 16;
    localparam int ecode_w   = 6;

    // EENTRY keeps only bits 31 to 6, the entry is 64-byte aligned.
    localparam int eentry_lsb = 6;

    // LIE and IS pack CSR bits 12, 11 and 9 to 0 into one vector.
    localparam int int_lines = 12;

    // hardware lines land in IS bits 9 to 2.
    localparam int hw_irq_lines = 8;
    localparam int hw_irq_lsb   = 2;

endpackage

// ==== logic/csr_regs.sv ====
`timescale 1ns/1ps

module csr_regs
    import csr_pkg::*;
    import pipe_pkg::*;
#(
    parameter logic [31:0] eentry_reset = 32'h0
) (
    input  logic                    clk,
    input  logic                    rst_i,
    input  logic                    csr_we_i,
    input  logic [csr_addr_w-1:0]   csr_waddr_i,
    input  logic [31:0]             csr_wdata_i,
    input  logic [hw_irq_lines-1:0] irq_i,
    input  logic                    trap_take_i,
    input  logic                    trap_ret_i,
    input  exc_code_e               trap_cause_i,
    input  logic [31:0]             trap_pc_i,
    input  logic [31:0]             trap_bad_addr_i,
    input  logic [csr_addr_w-1:0]   csr_raddr_i,
    output logic [31:0]             csr_rdata_o,
    output logic                    crmd_ie_o,
    output logic [int_lines-1:0]    ecfg_lie_o,
    output logic [int_lines-1:0]    estat_is_o,
    output logic [31:0]             era_o,
    output logic [31:0]             eentry_o,
    output logic [31:0]             badv_o
);

    logic [plv_w-1:0]        crmd_plv;
    logic                    crmd_ie;
    logic [plv_w-1:0]        prmd_pplv;
    logic                    prmd_pie;
    logic [int_lines-1:0]    ecfg_lie;
    logic [int_lines-1:0]    estat_is;
    logic [ecode_w-1:0]      estat_ecode;
    logic [31:0]             era;
    logic [31:eentry_lsb]    eentry;
    logic [31:0]             badv;

    logic                    wr_crmd;
    logic                    wr_prmd;
    logic [plv_w-1:0]        crmd_plv_cur;
    logic                    crmd_ie_cur;
    logic [plv_w-1:0]        prmd_pplv_cur;
    logic                    prmd_pie_cur;

    assign wr_crmd = csr_we_i && (csr_waddr_i == csr_addr_crmd);
    assign wr_prmd = csr_we_i && (csr_waddr_i == csr_addr_prmd);

    // the writeback instruction is older, so a trap sees its CRMD and PRMD write.
    assign crmd_plv_cur  = wr_crmd ? csr_wdata_i[plv_w-1:0] : crmd_plv;
    assign crmd_ie_cur   = wr_crmd ? csr_wdata_i[crmd_ie_bit] : crmd_ie;
    assign prmd_pplv_cur = wr_prmd ? csr_wdata_i[plv_w-1:0] : prmd_pplv;
    assign prmd_pie_cur  = wr_prmd ? csr_wdata_i[crmd_ie_bit] : prmd_pie;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            crmd_plv    <= '0;
            crmd_ie     <= 1'b0;
            prmd_pplv   <= '0;
            prmd_pie    <= 1'b0;
            ecfg_lie    <= '0;
            estat_is    <= '0;
            estat_ecode <= '0;
            era         <= '0;
            eentry      <= eentry_reset[31:eentry_lsb];
            badv        <= '0;
        end else begin
            estat_is[hw_irq_lsb +: hw_irq_lines] <= irq_i;

            if (csr_we_i) begin
                case (csr_waddr_i)
                    csr_addr_ecfg: begin
                        ecfg_lie <= {csr_wdata_i[12:11], csr_wdata_i[9:0]};
                    end
                    csr_addr_estat: begin
                        estat_is[11:10] <= csr_wdata_i[12:11]; // only the software bits.
                        estat_is[1:0]   <= csr_wdata_i[1:0];
                    end
                    csr_addr_era: begin
                        era <= csr_wdata_i;
                    end
                    csr_addr_eentry: begin
                        eentry <= csr_wdata_i[31:eentry_lsb];
                    end
                    default: begin
                    end
                endcase
            end

            if (trap_take_i) begin
                prmd_pplv   <= crmd_plv_cur;
                prmd_pie    <= crmd_ie_cur;
                crmd_plv    <= '0;
                crmd_ie     <= 1'b0;
                era         <= trap_pc_i; // overrides a same-cycle ERA write.
                estat_ecode <= trap_cause_i;
                if (trap_cause_i == exc_ade || trap_cause_i == exc_ale) begin
                    badv <= trap_bad_addr_i;
                end
            end else if (trap_ret_i) begin
                crmd_plv  <= prmd_pplv_cur;
                crmd_ie   <= prmd_pie_cur;
                prmd_pplv <= prmd_pplv_cur;
                prmd_pie  <= prmd_pie_cur;
            end else begin
                crmd_plv  <= crmd_plv_cur;
                crmd_ie   <= crmd_ie_cur;
                prmd_pplv <= prmd_pplv_cur;
                prmd_pie  <= prmd_pie_cur;
            end
        end
    end

    always_comb begin
        csr_rdata_o = '0;
        case (csr_raddr_i)
            csr_addr_crmd: begin
                csr_rdata_o[plv_w-1:0]   = crmd_plv;
                csr_rdata_o[crmd_ie_bit] = crmd_ie;
            end
            csr_addr_prmd: begin
                csr_rdata_o[plv_w-1:0]   = prmd_pplv;
                csr_rdata_o[crmd_ie_bit] = prmd_pie;
            end
            csr_addr_ecfg: begin
                csr_rdata_o[12:11] = ecfg_lie[11:10];
                csr_rdata_o[9:0]   = ecfg_lie[9:0];
            end
            csr_addr_estat: begin
                csr_rdata_o[12:11]                  = estat_is[11:10];
                csr_rdata_o[9:0]                    = estat_is[9:0];
                csr_rdata_o[ecode_lsb +: ecode_w]   = estat_ecode;
            end
            csr_addr_era:    csr_rdata_o = era;
            csr_addr_badv:   csr_rdata_o = badv;
            csr_addr_eentry: csr_rdata_o = eentry_o;
            default:         csr_rdata_o = '0;
        endcase
    end

    assign crmd_ie_o  = crmd_ie;
    assign ecfg_lie_o = ecfg_lie;
    assign estat_is_o = estat_is;
    assign era_o      = era;
    assign eentry_o   = {eentry, {eentry_lsb{1'b0}}};
    assign badv_o     = badv;

endmodule

// ==== logic/exc_select.sv ====
`timescale 1ns/1ps

module exc_select
    import pipe_pkg::*;
(
    input  logic [exc_slots-1:0]            exc_valid_i,
    input  logic [exc_slots*exc_code_w-1:0] exc_code_i,
    input  logic                            ertn_i,
    output logic                            exc_taken_o,
    output exc_code_e                       exc_cause_o
);

    logic [exc_code_w-1:0] slot_code [exc_slots];

    always_comb begin
        for (int i = 0; i < exc_slots; i++) begin
            slot_code[i] = exc_code_i[i*exc_code_w +: exc_code_w];
        end
    end

    always_comb begin
        exc_taken_o = 1'b0;
        exc_cause_o = exc_none;
        if (exc_valid_i != '0) begin
            exc_taken_o = 1'b1;
            // lowest slot first so the highest valid slot is written last.
            for (int i = 0; i < exc_slots; i++) begin
                if (exc_valid_i[i]) begin
                    exc_cause_o = exc_code_e'(slot_code[i]);
                end
            end
        end
    end

endmodule

// ==== logic/except_unit.sv ====
`timescale 1ns/1ps

module except_unit
    import csr_pkg::*;
    import pipe_pkg::*;
#(
    parameter logic [31:0] eentry_reset = 32'h1c00_0000
) (
    input  logic                            clk,
    input  logic                            rst_i,
    input  logic [31:0]                     mem_pc_i,
    input  logic [exc_slots-1:0]            mem_exc_valid_i,
    input  logic [exc_slots*exc_code_w-1:0] mem_exc_code_i,
    input  logic [31:0]                     mem_bad_addr_i,
    input  logic                            mem_ertn_i,
    input  logic                            mem_idle_i,
    input  logic                            csr_we_i,
    input  logic [csr_addr_w-1:0]           csr_waddr_i,
    input  logic [31:0]                     csr_wdata_i,
    input  logic                            pause_if_i,
    input  logic                            pause_id_i,
    input  logic                            pause_dispatch_i,
    input  logic                            pause_ex_i,
    input  logic                            pause_mem_i,
    input  logic                            continue_idle_i,
    input  logic [hw_irq_lines-1:0]         irq_i,
    input  logic [csr_addr_w-1:0]           csr_raddr_i,
    output logic                            flush_o,
    output logic [31:0]                     new_pc_o,
    output logic [pause_w-1:0]              pause_o,
    output logic                            issue_en_o,
    output logic                            int_pending_o,
    output logic [31:0]                     csr_rdata_o
);

    logic                 exc_taken;
    exc_code_e            exc_cause;
    logic                 trap_take;
    logic                 trap_ret;
    logic                 crmd_ie;
    logic [int_lines-1:0] ecfg_lie;
    logic [int_lines-1:0] estat_is;
    logic [31:0]          era;
    logic [31:0]          eentry;
    logic [31:0]          era_fwd;
    logic [31:0]          eentry_fwd;

    exc_select i_exc_select (
        .exc_valid_i (mem_exc_valid_i),
        .exc_code_i  (mem_exc_code_i),
        .ertn_i      (mem_ertn_i),
        .exc_taken_o (exc_taken),
        .exc_cause_o (exc_cause)
    );

    int_check i_int_check (
        .csr_we_i      (csr_we_i),
        .csr_waddr_i   (csr_waddr_i),
        .csr_wdata_i   (csr_wdata_i),
        .crmd_ie_i     (crmd_ie),
        .ecfg_lie_i    (ecfg_lie),
        .estat_is_i    (estat_is),
        .era_i         (era),
        .eentry_i      (eentry),
        .era_fwd_o     (era_fwd),
        .eentry_fwd_o  (eentry_fwd),
        .int_pending_o (int_pending_o)
    );

    csr_regs #(
        .eentry_reset (eentry_reset)
    ) i_csr_regs (
        .clk             (clk),
        .rst_i           (rst_i),
        .csr_we_i        (csr_we_i),
        .csr_waddr_i     (csr_waddr_i),
        .csr_wdata_i     (csr_wdata_i),
        .irq_i           (irq_i),
        .trap_take_i     (trap_take),
        .trap_ret_i      (trap_ret),
        .trap_cause_i    (exc_cause),
        .trap_pc_i       (mem_pc_i),
        .trap_bad_addr_i (mem_bad_addr_i),
        .csr_raddr_i     (csr_raddr_i),
        .csr_rdata_o     (csr_rdata_o),
        .crmd_ie_o       (crmd_ie),
        .ecfg_lie_o      (ecfg_lie),
        .estat_is_o      (estat_is),
        .era_o           (era),
        .eentry_o        (eentry),
        .badv_o          ()
    );

    trap_ctrl i_trap_ctrl (
        .exc_taken_i      (exc_taken),
        .ertn_i           (mem_ertn_i),
        .idle_i           (mem_idle_i),
        .int_pending_i    (int_pending_o),
        .continue_idle_i  (continue_idle_i),
        .pause_if_i       (pause_if_i),
        .pause_id_i       (pause_id_i),
        .pause_dispatch_i (pause_dispatch_i),
        .pause_ex_i       (pause_ex_i),
        .pause_mem_i      (pause_mem_i),
        .era_fwd_i        (era_fwd),
        .eentry_fwd_i     (eentry_fwd),
        .flush_o          (flush_o),
        .new_pc_o         (new_pc_o),
        .pause_o          (pause_o),
        .issue_en_o       (issue_en_o),
        .trap_take_o      (trap_take),
        .trap_ret_o       (trap_ret)
    );

endmodule

// ==== logic/int_check.sv ====
`timescale 1ns/1ps

module int_check
    import csr_pkg::*;
(
    input  logic                  csr_we_i,
    input  logic [csr_addr_w-1:0] csr_waddr_i,
    input  logic [31:0]           csr_wdata_i,
    input  logic                  crmd_ie_i,
    input  logic [int_lines-1:0]  ecfg_lie_i,
    input  logic [int_lines-1:0]  estat_is_i,
    input  logic [31:0]           era_i,
    input  logic [31:0]           eentry_i,
    output logic [31:0]           era_fwd_o,
    output logic [31:0]           eentry_fwd_o,
    output logic                  int_pending_o
);

    logic                 hit_crmd;
    logic                 hit_ecfg;
    logic                 hit_estat;
    logic                 hit_era;
    logic                 hit_eentry;
    logic [int_lines-1:0] wdata_int;
    logic                 ie_fwd;
    logic [int_lines-1:0] lie_fwd;
    logic [int_lines-1:0] is_fwd;

    assign hit_crmd   = csr_we_i && (csr_waddr_i == csr_addr_crmd);
    assign hit_ecfg   = csr_we_i && (csr_waddr_i == csr_addr_ecfg);
    assign hit_estat  = csr_we_i && (csr_waddr_i == csr_addr_estat);
    assign hit_era    = csr_we_i && (csr_waddr_i == csr_addr_era);
    assign hit_eentry = csr_we_i && (csr_waddr_i == csr_addr_eentry);

    assign wdata_int = {csr_wdata_i[12:11], csr_wdata_i[9:0]}; // bit 10 is reserved.

    assign ie_fwd  = hit_crmd ? csr_wdata_i[crmd_ie_bit] : crmd_ie_i;
    assign lie_fwd = hit_ecfg ? wdata_int : ecfg_lie_i;
    assign is_fwd  = hit_estat ? wdata_int : estat_is_i;

    assign era_fwd_o = hit_era ? csr_wdata_i : era_i;

    // keep the same alignment that the stored EENTRY has.
    assign eentry_fwd_o = hit_eentry ? {csr_wdata_i[31:eentry_lsb], {eentry_lsb{1'b0}}} :
                                       eentry_i;

    assign int_pending_o = ie_fwd && ((lie_fwd & is_fwd) != '0);

endmodule

// ==== logic/pipe_pkg.sv ====
package pipe_pkg;

    localparam int exc_code_w = 6;

    // number of exception sources carried down the pipe, slot 5 wins.
    localparam int exc_slots = 6;

    // pause bits are pc, ibuf, decode, dispatch, ex, mem and wb.
    localparam int pause_w = 7;

    localparam logic [pause_w-1:0] pause_none     = 7'b0000000;
    localparam logic [pause_w-1:0] pause_from_if  = 7'b0000001;
    localparam logic [pause_w-1:0] pause_from_id  = 7'b0000111;
    localparam logic [pause_w-1:0] pause_from_dsp = 7'b0001111;
    localparam logic [pause_w-1:0] pause_from_ex  = 7'b0011111;
    localparam logic [pause_w-1:0] pause_from_mem = 7'b0111111;

    // ecode values follow the LoongArch encoding.
    typedef enum logic [exc_code_w-1:0] {
        exc_int  = 6'h00,
        exc_pil  = 6'h01,
        exc_pis  = 6'h02,
        exc_pif  = 6'h03,
        exc_pme  = 6'h04,
        exc_ppi  = 6'h07,
        exc_ade  = 6'h08,
        exc_ale  = 6'h09,
        exc_sys  = 6'h0b,
        exc_brk  = 6'h0c,
        exc_ine  = 6'h0d,
        exc_ipe  = 6'h0e,
        exc_fpd  = 6'h0f,
        exc_fpe  = 6'h12,
        exc_none = 6'h3f
    } exc_code_e;

endpackage

// ==== logic/trap_ctrl.sv ====
`timescale 1ns/1ps

module trap_ctrl
    import pipe_pkg::*;
(
    input  logic               exc_taken_i,
    input  logic               ertn_i,
    input  logic               idle_i,
    input  logic               int_pending_i,
    input  logic               continue_idle_i,
    input  logic               pause_if_i,
    input  logic               pause_id_i,
    input  logic               pause_dispatch_i,
    input  logic               pause_ex_i,
    input  logic               pause_mem_i,
    input  logic [31:0]        era_fwd_i,
    input  logic [31:0]        eentry_fwd_i,
    output logic               flush_o,
    output logic [31:0]        new_pc_o,
    output logic [pause_w-1:0] pause_o,
    output logic               issue_en_o,
    output logic               trap_take_o,
    output logic               trap_ret_o
);

    logic pause_idle;

    assign trap_take_o = exc_taken_i;
    assign trap_ret_o  = ertn_i && !exc_taken_i; // a faulting ertn traps instead.

    assign flush_o  = exc_taken_i || ertn_i;
    assign new_pc_o = trap_ret_o ? era_fwd_i : eentry_fwd_i;

    // idle holds the memory stage until an interrupt wakes it.
    assign pause_idle = idle_i && !int_pending_i && !continue_idle_i;

    always_comb begin
        if (pause_if_i) begin
            pause_o = pause_from_if;
        end else if (pause_id_i) begin
            pause_o = pause_from_id;
        end else if (pause_dispatch_i) begin
            pause_o = pause_from_dsp;
        end else if (pause_ex_i) begin
            pause_o = pause_from_ex;
        end else if (pause_mem_i || pause_idle) begin
            pause_o = pause_from_mem;
        end else begin
            pause_o = pause_none;
        end
    end

    assign issue_en_o = !pause_o[1]; // bit 1 is the instruction buffer.

endmodule

// ==== run.sh ====
#!/bin/sh
# build and run the except_unit testbench with Verilator.
rm -f sim.log
verilator --binary --timing -Wno-fatal -f filelist.f --top-module except_unit_tb \
    -o except_unit_sim > build.log 2>&1 \
    || { cat build.log; echo "build error"; exit 1; }
./obj_dir/except_unit_sim > sim.log 2>&1 || echo "simulator returned an error"
cat sim.log
grep -q "test passed" sim.log && ! grep -q "test failed" sim.log \
    || { echo "simulation did not pass"; exit 1; }
